//--- project.f
rtl/gfx_pkg.sv
rtl/fb_writer.sv
rtl/fb_mem_arbiter.sv
rtl/vga_timing.sv
rtl/vga_fb_pixel_stream.sv
rtl/cdc_fifo.sv
rtl/gfx_vga.sv
testbench/gfx_vga_tb.sv

//--- rtl/cdc_fifo.sv
`timescale 1ns/10ps

module cdc_fifo
  import gfx_pkg::*;
(
  // write side, clk domain
  input  logic      w_clk,
  input  logic      w_rst_n,
  input  logic      w_inc,
  input  vga_word_t w_data,
  output logic      w_almost_full,

  // read side, pixel_clk domain
  input  logic      r_clk,
  input  logic      r_rst_n,
  output vga_word_t vga_word,
  output logic      vga_valid
);

  vga_word_t fifo_mem [FIFO_DEPTH];

  logic [FIFO_ADDR_BITS:0] w_bin;
  logic [FIFO_ADDR_BITS:0] w_bin_next;
  logic [FIFO_ADDR_BITS:0] w_gray;
  logic [FIFO_ADDR_BITS:0] r_gray_meta;
  logic [FIFO_ADDR_BITS:0] r_gray_sync;
  logic [FIFO_ADDR_BITS:0] w_used;

  logic [FIFO_ADDR_BITS:0] r_bin;
  logic [FIFO_ADDR_BITS:0] r_bin_next;
  logic [FIFO_ADDR_BITS:0] r_gray;
  logic [FIFO_ADDR_BITS:0] w_gray_meta;
  logic [FIFO_ADDR_BITS:0] w_gray_sync;
  logic                    r_empty;

  function automatic logic [FIFO_ADDR_BITS:0] gray_to_bin(input logic [FIFO_ADDR_BITS:0] gray);
    logic [FIFO_ADDR_BITS:0] bin;
    bin[FIFO_ADDR_BITS] = gray[FIFO_ADDR_BITS];
    for (int i = FIFO_ADDR_BITS - 1; i >= 0; i--) begin
      bin[i] = bin[i + 1] ^ gray[i];
    end
    return bin;
  endfunction

  assign w_bin_next = w_bin + 1'b1;

  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      w_bin  <= '0;
      w_gray <= '0;
    end else if (w_inc) begin
      w_bin  <= w_bin_next;
      w_gray <= w_bin_next ^ (w_bin_next >> 1);
    end
  end

  always_ff @(posedge w_clk) begin
    if (w_inc) begin
      fifo_mem[w_bin[FIFO_ADDR_BITS-1:0]] <= w_data;
    end
  end

  always_ff @(posedge w_clk) begin
    if (!w_rst_n) begin
      r_gray_meta <= '0;
      r_gray_sync <= '0;
    end else begin
      r_gray_meta <= r_gray;
      r_gray_sync <= r_gray_meta;
    end
  end

  // stale read pointer only makes this pessimistic
  assign w_used        = w_bin - gray_to_bin(r_gray_sync);
  assign w_almost_full = (FIFO_DEPTH - w_used) <= FIFO_ALMOST_FULL;

  assign r_bin_next = r_bin + 1'b1;
  assign r_empty    = (r_gray == w_gray_sync);

  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      w_gray_meta <= '0;
      w_gray_sync <= '0;
    end else begin
      w_gray_meta <= w_gray;
      w_gray_sync <= w_gray_meta;
    end
  end

  // display side pops whenever anything is there
  always_ff @(posedge r_clk) begin
    if (!r_rst_n) begin
      r_bin     <= '0;
      r_gray    <= '0;
      vga_valid <= 1'b0;
    end else begin
      vga_valid <= !r_empty;
      if (!r_empty) begin
        r_bin  <= r_bin_next;
        r_gray <= r_bin_next ^ (r_bin_next >> 1);
      end
    end
  end

  always_ff @(posedge r_clk) begin
    if (!r_empty) begin
      vga_word <= fifo_mem[r_bin[FIFO_ADDR_BITS-1:0]];
    end
  end

endmodule

//--- rtl/fb_mem_arbiter.sv
`timescale 1ns/10ps

module fb_mem_arbiter
  import gfx_pkg::*;
(
  input  logic                    clk,

  // display reader, always wins
  input  logic                    rd_req,
  input  logic [FB_ADDR_BITS-1:0] rd_addr,
  output gfx_pixel_t              rd_data,

  // drawing writer
  input  logic                    wr_req,
  input  logic [FB_ADDR_BITS-1:0] wr_addr,
  input  gfx_pixel_t              wr_data,
  output logic                    wr_grant
);

  gfx_pixel_t fb_mem [FB_WORDS];

  // writer only gets the port in cycles the reader leaves idle
  assign wr_grant = wr_req && !rd_req;

  // single port, so at most one access per edge
  always_ff @(posedge clk) begin
    if (rd_req) begin
      rd_data <= fb_mem[rd_addr];
    end else if (wr_grant) begin
      fb_mem[wr_addr] <= wr_data;
    end
  end

endmodule

//--- rtl/fb_writer.sv
`timescale 1ns/10ps

module fb_writer
  import gfx_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [FB_X_BITS-1:0]    gfx_x,
  input  logic [FB_Y_BITS-1:0]    gfx_y,
  input  gfx_pixel_t              gfx_pixel,
  input  logic                    gfx_valid,
  output logic                    gfx_ready,
  output logic                    wr_req,
  output logic [FB_ADDR_BITS-1:0] wr_addr,
  output gfx_pixel_t              wr_data,
  input  logic                    wr_grant
);

  logic accept;

  // single holding slot, so ready is simply "slot empty"
  assign gfx_ready = !wr_req;
  assign accept    = gfx_valid && gfx_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_req <= 1'b0;
    end else if (accept) begin
      wr_req <= 1'b1;
    end else if (wr_grant) begin
      wr_req <= 1'b0;
    end
  end

  // row-major linear address
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr <= FB_ADDR_BITS'(gfx_y * H_VISIBLE + gfx_x);
      wr_data <= gfx_pixel;
    end
  end

endmodule

//--- rtl/gfx_pkg.sv
package gfx_pkg;

  // horizontal mode, in pixels
  localparam int H_VISIBLE     = 16;
  localparam int H_FRONT_PORCH = 2;
  localparam int H_SYNC_PULSE  = 3;
  localparam int H_BACK_PORCH  = 3;
  localparam int H_WHOLE_LINE  = H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE + H_BACK_PORCH;
  localparam int H_SYNC_START  = H_VISIBLE + H_FRONT_PORCH;
  localparam int H_SYNC_END    = H_SYNC_START + H_SYNC_PULSE;

  // vertical mode, in lines
  localparam int V_VISIBLE     = 12;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE  = 2;
  localparam int V_BACK_PORCH  = 1;
  localparam int V_WHOLE_FRAME = V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE + V_BACK_PORCH;
  localparam int V_SYNC_START  = V_VISIBLE + V_FRONT_PORCH;
  localparam int V_SYNC_END    = V_SYNC_START + V_SYNC_PULSE;

  localparam int FB_X_BITS    = 4;
  localparam int FB_Y_BITS    = 4;
  localparam int H_POS_BITS   = 5;
  localparam int V_POS_BITS   = 5;
  localparam int FB_ADDR_BITS = 8;
  localparam int FB_WORDS     = H_VISIBLE * V_VISIBLE;
  localparam int COLOR_BITS   = 4;
  localparam int META_BITS    = 2;

  localparam int FIFO_ADDR_BITS   = 4;
  localparam int FIFO_DEPTH       = 1 << FIFO_ADDR_BITS;
  localparam int FIFO_ALMOST_FULL = 8;

  // one framebuffer word
  typedef struct packed {
    logic [COLOR_BITS-1:0] red;
    logic [COLOR_BITS-1:0] grn;
    logic [COLOR_BITS-1:0] blu;
    logic [META_BITS-1:0]  meta;
  } gfx_pixel_t;

  // what crosses the fifo and goes out to the display
  typedef struct packed {
    logic       hsync;
    logic       vsync;
    gfx_pixel_t pixel;
  } vga_word_t;

endpackage

//--- rtl/gfx_vga.sv
`timescale 1ns/10ps

module gfx_vga
  import gfx_pkg::*;
(
  input  logic                 clk,
  input  logic                 pixel_clk,
  input  logic                 rst_n,

  // drawing client
  input  logic [FB_X_BITS-1:0] gfx_x,
  input  logic [FB_Y_BITS-1:0] gfx_y,
  input  gfx_pixel_t           gfx_pixel,
  input  logic                 gfx_valid,
  output logic                 gfx_ready,
  output logic                 gfx_vsync,

  // display side
  input  logic                 vga_enable,
  output vga_word_t            vga_word,
  output logic                 vga_valid
);

  logic                    wr_req;
  logic [FB_ADDR_BITS-1:0] wr_addr;
  gfx_pixel_t              wr_data;
  logic                    wr_grant;

  logic                    rd_req;
  logic [FB_ADDR_BITS-1:0] rd_addr;
  gfx_pixel_t              rd_data;

  logic                    stream_enable;
  logic                    stream_valid;
  vga_word_t               stream_word;
  logic                    fifo_almost_full;

  fb_writer fb_writer_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .gfx_x    (gfx_x),
    .gfx_y    (gfx_y),
    .gfx_pixel(gfx_pixel),
    .gfx_valid(gfx_valid),
    .gfx_ready(gfx_ready),
    .wr_req   (wr_req),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_grant (wr_grant)
  );

  fb_mem_arbiter fb_mem_arbiter_inst (
    .clk     (clk),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_req  (wr_req),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_grant(wr_grant)
  );

  // hold the raster while the fifo is close to full
  assign stream_enable = vga_enable && !fifo_almost_full;

  vga_fb_pixel_stream vga_fb_pixel_stream_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .enable      (stream_enable),
    .rd_req      (rd_req),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .stream_valid(stream_valid),
    .stream_word (stream_word),
    .gfx_vsync   (gfx_vsync)
  );

  cdc_fifo fifo (
    .w_clk        (clk),
    .w_rst_n      (rst_n),
    .w_inc        (stream_valid),
    .w_data       (stream_word),
    .w_almost_full(fifo_almost_full),
    .r_clk        (pixel_clk),
    .r_rst_n      (rst_n),
    .vga_word     (vga_word),
    .vga_valid    (vga_valid)
  );

endmodule

//--- rtl/vga_fb_pixel_stream.sv
`timescale 1ns/10ps

module vga_fb_pixel_stream
  import gfx_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    enable,

  // framebuffer read port
  output logic                    rd_req,
  output logic [FB_ADDR_BITS-1:0] rd_addr,
  input  gfx_pixel_t              rd_data,

  // pixel stream towards the fifo
  output logic                    stream_valid,
  output vga_word_t               stream_word,
  output logic                    gfx_vsync
);

  logic [H_POS_BITS-1:0] h_pos;
  logic [V_POS_BITS-1:0] v_pos;
  logic                  hsync;
  logic                  vsync;
  logic                  visible;

  // stage 2 side info
  logic                  s2_hsync;
  logic                  s2_vsync;
  logic                  s2_visible;

  vga_timing vga_timing_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .advance(enable),
    .h_pos  (h_pos),
    .v_pos  (v_pos),
    .hsync  (hsync),
    .vsync  (vsync),
    .visible(visible)
  );

  // stage 1: fetch only inside the visible area
  assign rd_req  = enable && visible;
  assign rd_addr = FB_ADDR_BITS'(v_pos * H_VISIBLE + h_pos);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stream_valid <= 1'b0;
    end else begin
      stream_valid <= enable;
    end
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      s2_hsync   <= hsync;
      s2_vsync   <= vsync;
      s2_visible <= visible;
    end
  end

  // stage 2: read data lands here one cycle after the request
  always_comb begin
    stream_word.hsync = s2_hsync;
    stream_word.vsync = s2_vsync;
    if (s2_visible) begin
      stream_word.pixel = rd_data;
    end else begin
      stream_word.pixel = '0;
    end
  end

  // vsync back to the drawing client, clk domain
  assign gfx_vsync = stream_valid && s2_vsync;

endmodule

//--- rtl/vga_timing.sv
`timescale 1ns/10ps

module vga_timing
  import gfx_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  advance,
  output logic [H_POS_BITS-1:0] h_pos,
  output logic [V_POS_BITS-1:0] v_pos,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  visible
);

  logic h_last;
  logic v_last;

  assign h_last = (h_pos == H_POS_BITS'(H_WHOLE_LINE - 1));
  assign v_last = (v_pos == V_POS_BITS'(V_WHOLE_FRAME - 1));

  // raster counters, only step when the stream takes a position
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_pos <= '0;
      v_pos <= '0;
    end else if (advance) begin
      if (h_last) begin
        h_pos <= '0;
        if (v_last) begin
          v_pos <= '0;
        end else begin
          v_pos <= v_pos + 1'b1;
        end
      end else begin
        h_pos <= h_pos + 1'b1;
      end
    end
  end

  // sync is active high in this mode
  assign hsync   = (h_pos >= H_SYNC_START) && (h_pos < H_SYNC_END);
  assign vsync   = (v_pos >= V_SYNC_START) && (v_pos < V_SYNC_END);
  assign visible = (h_pos < H_VISIBLE) && (v_pos < V_VISIBLE);

endmodule

//--- testbench/gfx_vga_tb.sv
`timescale 1ns/10ps

module gfx_vga_tb
  import gfx_pkg::*;
();

  logic                 clk;
  logic                 pixel_clk;
  logic                 rst_n;
  logic [FB_X_BITS-1:0] gfx_x;
  logic [FB_Y_BITS-1:0] gfx_y;
  gfx_pixel_t           gfx_pixel;
  logic                 gfx_valid;
  logic                 gfx_ready;
  logic                 gfx_vsync;
  logic                 vga_enable;
  vga_word_t            vga_word;
  logic                 vga_valid;

  // shadow copy of what the client has written
  gfx_pixel_t shadow_fb [FB_WORDS];

  int   exp_h          = 0;
  int   exp_v          = 0;
  int   frames_checked = 0;
  int   cycle_count    = 0;
  int   vsync_cycles   = 0;
  int   vsync_expected = 0;
  logic fill_done      = 1'b0;
  logic check_pixels   = 1'b0;

  gfx_vga dut (
    .clk       (clk),
    .pixel_clk (pixel_clk),
    .rst_n     (rst_n),
    .gfx_x     (gfx_x),
    .gfx_y     (gfx_y),
    .gfx_pixel (gfx_pixel),
    .gfx_valid (gfx_valid),
    .gfx_ready (gfx_ready),
    .gfx_vsync (gfx_vsync),
    .vga_enable(vga_enable),
    .vga_word  (vga_word),
    .vga_valid (vga_valid)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // offset so pixel_clk edges never line up with the drive time
  initial begin
    pixel_clk = 1'b0;
    #10;
    forever begin
      #80 pixel_clk = ~pixel_clk;
    end
  end

  // expected display word at a raster position
  function automatic vga_word_t expected_word(input int h, input int v);
    vga_word_t w;
    w.hsync = (h >= H_VISIBLE + H_FRONT_PORCH) &&
              (h < H_VISIBLE + H_FRONT_PORCH + H_SYNC_PULSE);
    w.vsync = (v >= V_VISIBLE + V_FRONT_PORCH) &&
              (v < V_VISIBLE + V_FRONT_PORCH + V_SYNC_PULSE);
    if (h < H_VISIBLE && v < V_VISIBLE) begin
      w.pixel = shadow_fb[v * H_VISIBLE + h];
    end else begin
      w.pixel = '0;
    end
    return w;
  endfunction

  task automatic check_equal(input logic [15:0] got, input logic [15:0] expected,
                             input string what);
    if (got !== expected) begin
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, expected);
      $display("TEST FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  // called at the drive point and returns there after acceptance
  task automatic write_pixel(input int addr, input gfx_pixel_t pix);
    logic ready_now;
    gfx_x     = FB_X_BITS'(addr % H_VISIBLE);
    gfx_y     = FB_Y_BITS'(addr / H_VISIBLE);
    gfx_pixel = pix;
    gfx_valid = 1'b1;
    do begin
      ready_now = gfx_ready;
      @(posedge clk);
      #10;
    end while (!ready_now);
    shadow_fb[addr] = pix;
    gfx_valid       = 1'b0;
  endtask

  task automatic fill_framebuffer();
    int          order [FB_WORDS];
    int          j;
    int          tmp;
    logic [31:0] rnd;
    for (int i = 0; i < FB_WORDS; i++) begin
      order[i] = i;
    end
    // shuffle so locations are written in random order
    for (int i = FB_WORDS - 1; i > 0; i--) begin
      j        = $urandom % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < FB_WORDS; i++) begin
      rnd = $urandom;
      write_pixel(order[i], rnd[$bits(gfx_pixel_t)-1:0]);
    end
  endtask

  task automatic wait_vsync_rises(input int count);
    int   rises;
    logic prev;
    rises = 0;
    prev  = gfx_vsync;
    while (rises < count) begin
      @(posedge clk);
      #10;
      if (gfx_vsync && !prev) begin
        rises++;
      end
      prev = gfx_vsync;
    end
  endtask

  task automatic drop_enable_randomly(input int span);
    int elapsed;
    int len;
    elapsed = 0;
    while (elapsed < span) begin
      len = 20 + ($urandom % 40);
      vga_enable = 1'b1;
      repeat (len) @(posedge clk);
      #10;
      elapsed += len;
      len = 4 + ($urandom % 16);
      vga_enable = 1'b0;
      repeat (len) @(posedge clk);
      #10;
      elapsed += len;
    end
    vga_enable = 1'b1;
  endtask

  // clk cycles in which the drawing side sees vsync
  always @(negedge clk) begin
    if (rst_n === 1'b1 && gfx_vsync !== 1'b0) begin
      vsync_cycles++;
    end
  end

  // output checker sampled away from pixel_clk rising edges
  always @(negedge pixel_clk) begin : check_output
    vga_word_t exp_word;
    logic      visible;
    if (rst_n === 1'b1 && vga_valid === 1'b1) begin
      if (exp_h == 0 && exp_v == 0 && fill_done && !check_pixels) begin
        check_pixels = 1'b1;
      end
      // every vsync word of earlier frames has left stage 2 by now
      if (exp_h == 0 && exp_v == 0) begin
        check_equal(vsync_cycles, vsync_expected,
                    $sformatf("gfx_vsync cycles before frame start at %0d", vsync_expected));
      end
      exp_word = expected_word(exp_h, exp_v);
      visible  = (exp_h < H_VISIBLE) && (exp_v < V_VISIBLE);
      check_equal(vga_word.hsync, exp_word.hsync,
                  $sformatf("hsync at (%0d,%0d)", exp_h, exp_v));
      check_equal(vga_word.vsync, exp_word.vsync,
                  $sformatf("vsync at (%0d,%0d)", exp_h, exp_v));
      // visible data is only known once the whole framebuffer is written
      if (!visible || check_pixels) begin
        check_equal(vga_word.pixel, exp_word.pixel,
                    $sformatf("pixel at (%0d,%0d)", exp_h, exp_v));
      end
      if (exp_word.vsync) begin
        vsync_expected++;
      end
      if (exp_h == H_WHOLE_LINE - 1) begin
        exp_h = 0;
        if (exp_v == V_WHOLE_FRAME - 1) begin
          exp_v = 0;
          if (check_pixels) begin
            frames_checked++;
          end
        end else begin
          exp_v++;
        end
      end else begin
        exp_h++;
      end
    end
  end

  // timeout after eight frames of pixel_clk time counted in clk cycles
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= 5000) begin
      $display("timeout: two whole frames were not checked within 5000 clk cycles");
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    void'($urandom(32'hb1cf));
    rst_n      = 1'b0;
    gfx_x      = '0;
    gfx_y      = '0;
    gfx_pixel  = '0;
    gfx_valid  = 1'b0;
    vga_enable = 1'b1;
    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;

    fill_framebuffer();
    wait_vsync_rises(2);
    fill_done = 1'b1;

    // stall the raster inside the first checked frame
    wait (check_pixels);
    @(posedge clk);
    #10;
    drop_enable_randomly(500);

    wait (frames_checked == 2);
    $display("TEST PASSED");
    $finish;
  end

endmodule
